//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_execute_top
FLIST     ?= execute_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wall -Wno-fatal

SRCS    := $(shell cat $(FLIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- execute_top.f
source/mips_pkg.sv
source/alu.sv
source/forwarding_unit.sv
source/register_bank.sv
source/instruction_execute.sv
source/data_memory_stage.sv
source/execute_top.sv
test/tb_execute_top.sv

//--- source/alu.sv
`timescale 1ns/1ps

module alu import mips_pkg::*; (
  input  alu_op_e     i_op,
  input  logic [31:0] i_data_a,
  input  logic [31:0] i_data_b,
  input  logic [4:0]  i_shamt,
  output logic [31:0] o_data
);

  always_comb begin
    case (i_op)
      ADD, ADDU, ADDI, ADDIU: begin
        o_data = i_data_a + i_data_b;  // no overflow trap
      end
      SUB, SUBU: begin
        o_data = i_data_a - i_data_b;
      end
      AND, ANDI: begin
        o_data = i_data_a & i_data_b;
      end
      OR, ORI: begin
        o_data = i_data_a | i_data_b;
      end
      XOR, XORI: begin
        o_data = i_data_a ^ i_data_b;
      end
      NOR: begin
        o_data = ~(i_data_a | i_data_b);
      end
      SLT, SLTI: begin
        o_data = {31'b0, $signed(i_data_a) < $signed(i_data_b)};
      end
      SLTU, SLTIU: begin
        o_data = {31'b0, i_data_a < i_data_b};
      end
      SLL:  o_data = i_data_b << i_shamt;  // shifts act on rt
      SRL:  o_data = i_data_b >> i_shamt;
      SRA:  o_data = $signed(i_data_b) >>> i_shamt;
      SLLV: o_data = i_data_b << i_data_a[4:0];  // amount from rs
      SRLV: o_data = i_data_b >> i_data_a[4:0];
      SRAV: o_data = $signed(i_data_b) >>> i_data_a[4:0];
      LUI: begin
        o_data = {i_data_b[15:0], 16'h0000};  // immediate to upper half
      end
      default: begin
        o_data = 32'h0000_0000;  // idle and unknown codes
      end
    endcase
  end

endmodule

//--- source/data_memory_stage.sv
`timescale 1ns/1ps

module data_memory_stage import mips_pkg::*; #(
  parameter int MEM_ADDR_BITS = 8  // word address width
) (
  input  logic    i_clk,
  input  logic    i_reset,
  input  ex_mem_t i_ex_mem,
  output wb_t     o_wb
);

  logic [31:0]              mem [0:(2**MEM_ADDR_BITS)-1];
  logic [MEM_ADDR_BITS-1:0] word_addr;
  logic [1:0]               lane;        // byte offset in the word
  logic [3:0]               byte_en;
  logic [31:0]              wr_data;     // store data replicated over lanes
  logic [31:0]              rd_word;
  logic [7:0]               rd_byte;
  logic [15:0]              rd_half;
  logic [31:0]              load_data;

  assign word_addr = i_ex_mem.alu_result[MEM_ADDR_BITS+1:2];
  assign lane      = i_ex_mem.alu_result[1:0];

  always_comb begin
    case (i_ex_mem.mem_size)
      BYTE: begin
        byte_en = 4'b0001 << lane;
        wr_data = {4{i_ex_mem.store_data[7:0]}};
      end
      HALF: begin
        byte_en = lane[1] ? 4'b1100 : 4'b0011;
        wr_data = {2{i_ex_mem.store_data[15:0]}};
      end
      default: begin
        byte_en = 4'b1111;  // word
        wr_data = i_ex_mem.store_data;
      end
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_ex_mem.mem_write) begin
      for (int i = 0; i < 4; i++) begin
        if (byte_en[i]) begin
          mem[word_addr][8*i +: 8] <= wr_data[8*i +: 8];  // little endian lanes
        end
      end
    end
  end

  assign rd_word = mem[word_addr];
  assign rd_byte = rd_word[{lane, 3'b000} +: 8];
  assign rd_half = rd_word[{lane[1], 4'b0000} +: 16];

  always_comb begin
    case (i_ex_mem.mem_size)
      BYTE:    load_data = {{24{rd_byte[7] & ~i_ex_mem.mem_unsigned}}, rd_byte};
      HALF:    load_data = {{16{rd_half[15] & ~i_ex_mem.mem_unsigned}}, rd_half};
      default: load_data = rd_word;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_wb <= '0;
    end else begin
      o_wb.write <= i_ex_mem.wb_write;
      o_wb.dest  <= i_ex_mem.write_reg;
      o_wb.data  <= i_ex_mem.mem_to_reg ? load_data : i_ex_mem.alu_result;
    end
  end

  // decode never issues a load and a store in one instruction
  assert property (@(posedge i_clk) disable iff (i_reset)
    !(i_ex_mem.mem_read && i_ex_mem.mem_write))
    else $error("data_memory_stage: read and write together");

  // half and word accesses stay inside one memory word
  assert property (@(posedge i_clk) disable iff (i_reset)
    (i_ex_mem.mem_read || i_ex_mem.mem_write) |->
      ((i_ex_mem.mem_size != HALF || lane[0] == 1'b0) &&
       (i_ex_mem.mem_size != WORD || lane == 2'b00)))
    else $error("data_memory_stage: misaligned access");

endmodule

//--- source/execute_top.sv
`timescale 1ns/1ps

module execute_top import mips_pkg::*; #(
  parameter int MEM_ADDR_BITS = 8
) (
  input  logic   i_clk,
  input  logic   i_reset,
  input  id_ex_t i_id_ex,
  output wb_t    o_wb  // also drives the bank write and the bypass
);

  logic [31:0] ra;
  logic [31:0] rb;
  fwd_sel_e    fwd_rs;
  fwd_sel_e    fwd_rt;
  ex_mem_t     ex_mem;

  register_bank u_register_bank (
    .i_clk   (i_clk),
    .i_reset (i_reset),
    .i_rs    (i_id_ex.rs),
    .i_rt    (i_id_ex.rt),
    .i_wb    (o_wb),
    .o_ra    (ra),
    .o_rb    (rb)
  );

  forwarding_unit u_forwarding_unit (
    .i_rs     (i_id_ex.rs),
    .i_rt     (i_id_ex.rt),
    .i_ex_mem (ex_mem),
    .i_wb     (o_wb),
    .o_fwd_rs (fwd_rs),
    .o_fwd_rt (fwd_rt)
  );

  instruction_execute u_instruction_execute (
    .i_clk            (i_clk),
    .i_reset          (i_reset),
    .i_id_ex          (i_id_ex),
    .i_ra             (ra),
    .i_rb             (rb),
    .i_fwd_rs         (fwd_rs),
    .i_fwd_rt         (fwd_rt),
    .i_mem_alu_result (ex_mem.alu_result),
    .i_wb_data        (o_wb.data),
    .o_ex_mem         (ex_mem)
  );

  data_memory_stage #(
    .MEM_ADDR_BITS (MEM_ADDR_BITS)
  ) u_data_memory_stage (
    .i_clk    (i_clk),
    .i_reset  (i_reset),
    .i_ex_mem (ex_mem),
    .o_wb     (o_wb)
  );

endmodule

//--- source/forwarding_unit.sv
`timescale 1ns/1ps

module forwarding_unit import mips_pkg::*; (
  input  logic [4:0] i_rs,
  input  logic [4:0] i_rt,
  input  ex_mem_t    i_ex_mem,
  input  wb_t        i_wb,
  output fwd_sel_e   o_fwd_rs,
  output fwd_sel_e   o_fwd_rt
);

  // memory stage wins over write-back, r0 is never bypassed
  function automatic fwd_sel_e pick(input logic [4:0] src, input ex_mem_t ex_mem, input wb_t wb);
    fwd_sel_e sel;
    if (ex_mem.wb_write && ex_mem.write_reg != 5'd0 && ex_mem.write_reg == src) begin
      sel = FWD_MEM;  // newest value
    end else if (wb.write && wb.dest != 5'd0 && wb.dest == src) begin
      sel = FWD_WB;
    end else begin
      sel = FWD_REG;  // bank already current
    end
    return sel;
  endfunction

  always_comb begin
    o_fwd_rs = pick(i_rs, i_ex_mem, i_wb);
    o_fwd_rt = pick(i_rt, i_ex_mem, i_wb);
  end

endmodule

//--- source/instruction_execute.sv
`timescale 1ns/1ps

module instruction_execute import mips_pkg::*; (
  input  logic        i_clk,
  input  logic        i_reset,
  input  id_ex_t      i_id_ex,
  input  logic [31:0] i_ra,
  input  logic [31:0] i_rb,
  input  fwd_sel_e    i_fwd_rs,
  input  fwd_sel_e    i_fwd_rt,
  input  logic [31:0] i_mem_alu_result,
  input  logic [31:0] i_wb_data,
  output ex_mem_t     o_ex_mem
);

  alu_op_e     alu_op;
  logic        is_jump;     // jal or jalr
  logic [31:0] data_a;
  logic [31:0] rt_value;    // bypassed rt, also the store data
  logic [31:0] data_b;
  logic [31:0] alu_result;

  function automatic logic [31:0] bypass(input fwd_sel_e sel, input logic [31:0] bank,
                                         input logic [31:0] mem, input logic [31:0] wb);
    logic [31:0] value;
    case (sel)
      FWD_MEM: value = mem;
      FWD_WB:  value = wb;
      default: value = bank;  // FWD_REG
    endcase
    return value;
  endfunction

  always_comb begin
    case (i_id_ex.alu_class)
      ADDR:    alu_op = ADD;                         // address or link sum
      BRANCH:  alu_op = IDLE;
      RTYPE:   alu_op = alu_op_e'(i_id_ex.funct);
      ITYPE:   alu_op = alu_op_e'(i_id_ex.opcode);
      default: alu_op = IDLE;
    endcase
  end

  assign is_jump = (i_id_ex.opcode == OPC_JAL) ||
                   (i_id_ex.opcode == OPC_RTYPE && i_id_ex.funct == FUNCT_JALR);

  always_comb begin
    if (is_jump) begin
      data_a   = i_ra;  // jumps take the bank values as they are
      rt_value = i_rb;
    end else begin
      data_a   = bypass(i_fwd_rs, i_ra, i_mem_alu_result, i_wb_data);
      rt_value = bypass(i_fwd_rt, i_rb, i_mem_alu_result, i_wb_data);
    end
    data_b = i_id_ex.alu_src ? i_id_ex.imm : rt_value;
  end

  alu u_alu (
    .i_op     (alu_op),
    .i_data_a (data_a),
    .i_data_b (data_b),
    .i_shamt  (i_id_ex.shamt),
    .o_data   (alu_result)
  );

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_ex_mem <= '0;  // bubble with zero data
    end else begin
      o_ex_mem.wb_write     <= i_id_ex.wb_write;
      o_ex_mem.mem_to_reg   <= i_id_ex.mem_to_reg;
      o_ex_mem.mem_read     <= i_id_ex.mem_read;
      o_ex_mem.mem_write    <= i_id_ex.mem_write;
      o_ex_mem.mem_unsigned <= i_id_ex.mem_unsigned;
      o_ex_mem.mem_size     <= i_id_ex.mem_size;
      o_ex_mem.write_reg    <= i_id_ex.reg_dst ? i_id_ex.rd : i_id_ex.rt;
      o_ex_mem.alu_result   <= alu_result;
      o_ex_mem.store_data   <= rt_value;
    end
  end

endmodule

//--- source/mips_pkg.sv
package mips_pkg;

  // alu operations share the mips funct and i-type opcode encodings
  typedef enum logic [5:0] {
    SLL   = 6'b000000,
    SRL   = 6'b000010,
    SRA   = 6'b000011,
    SLLV  = 6'b000100,
    SRLV  = 6'b000110,
    SRAV  = 6'b000111,
    ADDI  = 6'b001000,  // opcode
    ADDIU = 6'b001001,  // opcode
    SLTI  = 6'b001010,  // opcode
    SLTIU = 6'b001011,  // opcode
    ANDI  = 6'b001100,  // opcode
    ORI   = 6'b001101,  // opcode
    XORI  = 6'b001110,  // opcode
    LUI   = 6'b001111,  // opcode
    ADD   = 6'b100000,
    ADDU  = 6'b100001,
    SUB   = 6'b100010,
    SUBU  = 6'b100011,
    AND   = 6'b100100,
    OR    = 6'b100101,
    XOR   = 6'b100110,
    NOR   = 6'b100111,
    SLT   = 6'b101010,
    SLTU  = 6'b101011,
    IDLE  = 6'b111111   // alu output forced to zero
  } alu_op_e;

  typedef enum logic [1:0] {
    ADDR   = 2'b00,  // load, store, jal, jalr
    BRANCH = 2'b01,  // resolved in decode
    RTYPE  = 2'b10,  // op from funct
    ITYPE  = 2'b11   // op from opcode
  } alu_class_e;

  typedef enum logic [1:0] {
    FWD_REG = 2'b00,  // register bank
    FWD_WB  = 2'b01,  // write-back bus
    FWD_MEM = 2'b10   // alu result held in ex/mem
  } fwd_sel_e;

  typedef enum logic [1:0] {
    BYTE = 2'b00,
    HALF = 2'b01,
    WORD = 2'b11
  } mem_size_e;

  localparam logic [5:0] OPC_RTYPE  = 6'b000000;
  localparam logic [5:0] OPC_JAL    = 6'b000011;
  localparam logic [5:0] FUNCT_JALR = 6'b001001;

  typedef struct packed {
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [5:0]  funct;
    logic [5:0]  opcode;
    logic [4:0]  shamt;
    logic [31:0] imm;           // already sign or zero extended
    logic        wb_write;      // writes the register bank
    logic        mem_to_reg;    // write back the load value
    logic        mem_read;
    logic        mem_write;
    logic        mem_unsigned;  // zero extend loads
    mem_size_e   mem_size;
    logic        alu_src;       // b operand is the immediate
    logic        reg_dst;       // destination is rd, else rt
    alu_class_e  alu_class;
  } id_ex_t;

  typedef struct packed {
    logic        wb_write;
    logic        mem_to_reg;
    logic        mem_read;
    logic        mem_write;
    logic        mem_unsigned;
    mem_size_e   mem_size;
    logic [4:0]  write_reg;
    logic [31:0] alu_result;  // also the memory byte address
    logic [31:0] store_data;
  } ex_mem_t;

  typedef struct packed {
    logic        write;
    logic [4:0]  dest;  // destination register number
    logic [31:0] data;
  } wb_t;

endpackage

//--- source/register_bank.sv
`timescale 1ns/1ps

module register_bank import mips_pkg::*; (
  input  logic        i_clk,
  input  logic        i_reset,
  input  logic [4:0]  i_rs,
  input  logic [4:0]  i_rt,
  input  wb_t         i_wb,
  output logic [31:0] o_ra,
  output logic [31:0] o_rb
);

  logic [31:0] regs [0:31];
  logic        wr_en;  // qualified write, r0 excluded

  assign wr_en = i_wb.write && (i_wb.dest != 5'd0);

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= 32'h0000_0000;
      end
    end else if (wr_en) begin
      regs[i_wb.dest] <= i_wb.data;
    end
  end

  // write-through so a reader in the write cycle sees the new value
  always_comb begin
    if (wr_en && i_wb.dest == i_rs) begin
      o_ra = i_wb.data;
    end else begin
      o_ra = regs[i_rs];  // r0 stays zero
    end
    if (wr_en && i_wb.dest == i_rt) begin
      o_rb = i_wb.data;
    end else begin
      o_rb = regs[i_rt];
    end
  end

endmodule

//--- test/tb_execute_top.sv
`timescale 1ns/1ps

module tb_execute_top import mips_pkg::*; ();

  localparam int TEST_CYCLES = 10 + 12 + 95 + 36 + 45 + 30;  // reset plus each test
  localparam int MAX_CYCLES  = TEST_CYCLES + 60;              // margin

  logic        i_clk = 1'b0;
  logic        i_reset;
  id_ex_t      id_ex;
  wb_t         o_wb;
  logic [31:0] regs_m [32];    // model registers, in program order
  logic [31:0] bank_m [32];    // what the bank shows, last write still pending
  logic [7:0]  mem_m [1024];   // model bytes, little endian
  wb_t         exp_q [$];
  int          due_q [$];      // cycle in which o_wb must match
  wb_t         exp_head;
  int          cyc;
  int          checks;
  int          errors;
  int          test_errors;
  string       test_name;

  always #4 i_clk = ~i_clk;  // 8 ns period

  execute_top #(.MEM_ADDR_BITS(8)) u_dut (
    .i_clk   (i_clk),
    .i_reset (i_reset),
    .i_id_ex (id_ex),
    .o_wb    (o_wb)
  );

  task automatic check(input string name, input logic [37:0] exp_v, input logic [37:0] act_v);
    checks++;
    if (act_v !== exp_v) begin
      errors++;
      $display("FAIL %s expected %h actual %h", name, exp_v, act_v);
    end
  endtask

  function automatic logic [31:0] sext16(input logic [15:0] v);
    return {{16{v[15]}}, v};
  endfunction

  // reference alu, written from the instruction set definition
  function automatic logic [31:0] alu_model(input logic [5:0] code, input logic [31:0] a,
                                            input logic [31:0] b, input logic [4:0] sh);
    case (alu_op_e'(code))
      ADD, ADDU, ADDI, ADDIU: return a + b;
      SUB, SUBU:              return a - b;
      AND, ANDI:              return a & b;
      OR, ORI:                return a | b;
      XOR, XORI:              return a ^ b;
      NOR:                    return ~(a | b);
      SLT, SLTI:              return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      SLTU, SLTIU:            return (a < b) ? 32'd1 : 32'd0;
      SLL:                    return b << sh;
      SRL:                    return b >> sh;
      SRA:                    return $unsigned($signed(b) >>> sh);
      SLLV:                   return b << a[4:0];
      SRLV:                   return b >> a[4:0];
      SRAV:                   return $unsigned($signed(b) >>> a[4:0]);
      LUI:                    return {b[15:0], 16'h0000};
      default:                return 32'h0000_0000;
    endcase
  endfunction

  task automatic model_step(input id_ex_t ins, output wb_t e);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [31:0] ld;
    logic        jump;
    jump = ins.opcode == OPC_JAL || (ins.opcode == OPC_RTYPE && ins.funct == FUNCT_JALR);
    a = jump ? bank_m[ins.rs] : regs_m[ins.rs];  // jumps see the bank only
    b = jump ? bank_m[ins.rt] : regs_m[ins.rt];
    case (ins.alu_class)
      ADDR:    res = a + (ins.alu_src ? ins.imm : b);
      RTYPE:   res = alu_model(ins.funct, a, ins.alu_src ? ins.imm : b, ins.shamt);
      ITYPE:   res = alu_model(ins.opcode, a, ins.alu_src ? ins.imm : b, ins.shamt);
      default: res = 32'h0000_0000;
    endcase
    for (int i = 0; i < 32; i++) bank_m[i] = regs_m[i];
    if (ins.mem_write) begin
      mem_m[res[9:0]] = b[7:0];
      if (ins.mem_size != BYTE) mem_m[res[9:0] + 10'd1] = b[15:8];
      if (ins.mem_size == WORD) begin
        mem_m[res[9:0] + 10'd2] = b[23:16];
        mem_m[res[9:0] + 10'd3] = b[31:24];
      end
    end
    case (ins.mem_size)
      BYTE:    ld = {{24{mem_m[res[9:0]][7] & ~ins.mem_unsigned}}, mem_m[res[9:0]]};
      HALF:    ld = {{16{mem_m[res[9:0] + 10'd1][7] & ~ins.mem_unsigned}},
                     mem_m[res[9:0] + 10'd1], mem_m[res[9:0]]};
      default: ld = {mem_m[res[9:0] + 10'd3], mem_m[res[9:0] + 10'd2],
                     mem_m[res[9:0] + 10'd1], mem_m[res[9:0]]};
    endcase
    e.write = ins.wb_write;
    e.dest  = ins.reg_dst ? ins.rd : ins.rt;
    e.data  = ins.mem_to_reg ? ld : res;
    if (e.write && e.dest != 5'd0) regs_m[e.dest] = e.data;
  endtask

  // drive one instruction for one cycle and queue its write-back
  task automatic issue(input id_ex_t ins);
    wb_t e;
    @(posedge i_clk);
    id_ex <= ins;
    model_step(ins, e);
    exp_q.push_back(e);
    due_q.push_back(cyc + 2);
  endtask

  function automatic id_ex_t rtype(input alu_op_e f, input logic [4:0] rd, input logic [4:0] rs,
                                   input logic [4:0] rt, input logic [4:0] sh);
    id_ex_t ins;
    ins = '0;
    ins.funct = f;
    ins.rd = rd;
    ins.rs = rs;
    ins.rt = rt;
    ins.shamt = sh;
    ins.wb_write = 1'b1;
    ins.reg_dst = 1'b1;
    ins.alu_class = RTYPE;
    return ins;
  endfunction

  function automatic id_ex_t itype(input alu_op_e op, input logic [4:0] rt, input logic [4:0] rs,
                                   input logic [31:0] imm);
    id_ex_t ins;
    ins = '0;
    ins.opcode = op;
    ins.rt = rt;
    ins.rs = rs;
    ins.imm = imm;
    ins.wb_write = 1'b1;
    ins.alu_src = 1'b1;
    ins.alu_class = ITYPE;
    return ins;
  endfunction

  // sized access at rs + imm, store when st is set
  function automatic id_ex_t mem_op(input logic st, input mem_size_e sz, input logic uns,
                                    input logic [4:0] rt, input logic [4:0] rs,
                                    input logic [31:0] imm);
    id_ex_t ins;
    ins = '0;
    ins.opcode = st ? 6'b101011 : 6'b100011;
    ins.rt = rt;
    ins.rs = rs;
    ins.imm = imm;
    ins.mem_size = sz;
    ins.mem_unsigned = uns;
    ins.mem_write = st;
    ins.mem_read = ~st;
    ins.mem_to_reg = ~st;
    ins.wb_write = ~st;
    ins.alu_src = 1'b1;
    ins.alu_class = ADDR;
    return ins;
  endfunction

  function automatic id_ex_t jump(input logic reg_form, input logic [4:0] rs,
                                  input logic [31:0] link);
    id_ex_t ins;
    ins = '0;
    ins.opcode = reg_form ? OPC_RTYPE : OPC_JAL;
    ins.funct = reg_form ? FUNCT_JALR : 6'd0;
    ins.rs = rs;
    ins.rt = 5'd31;
    ins.rd = 5'd31;
    ins.reg_dst = reg_form;
    ins.imm = link;
    ins.wb_write = 1'b1;
    ins.alu_src = 1'b1;
    ins.alu_class = ADDR;
    return ins;
  endfunction

  task automatic start_test(input string name);
    test_name = name;
    test_errors = errors;
  endtask

  task automatic end_test();
    repeat (3) issue('0);  // flush the pipe
    while (exp_q.size() != 0) @(negedge i_clk);
    $display("%s: done, %0d errors", test_name, errors - test_errors);
  endtask

  task automatic test_reset();
    start_test("reset");
    for (int k = 1; k < 5; k++) issue(rtype(ADDU, 5'(k), 5'(k), 5'(k + 8), 5'd0));
    end_test();
  endtask

  task automatic test_alu();
    alu_op_e r_ops [16] = '{ADD, ADDU, SUB, SUBU, AND, OR, XOR, NOR, SLT, SLTU,
                            SLL, SRL, SRA, SLLV, SRLV, SRAV};
    alu_op_e i_ops [8] = '{ADDI, ADDIU, SLTI, SLTIU, ANDI, ORI, XORI, LUI};
    logic [15:0] v;
    start_test("alu");
    for (int k = 1; k < 5; k++) issue(itype(ADDIU, 5'(k), 5'd0, sext16(16'($urandom))));
    for (int k = 5; k < 9; k++) begin
      issue(itype(LUI, 5'(k), 5'd0, {16'h0, 16'($urandom)}));
      issue(itype(ORI, 5'(k), 5'(k), {16'h0, 16'($urandom)}));
    end
    foreach (r_ops[n]) begin
      issue(rtype(r_ops[n], 5'(9 + n % 7), 5'(1 + $urandom % 8), 5'(1 + $urandom % 8),
                  5'($urandom)));
      issue('0);
    end
    foreach (i_ops[n]) begin
      v = 16'($urandom);
      issue(itype(i_ops[n], 5'(9 + n), 5'(1 + $urandom % 8),
                  (n < 4) ? sext16(v) : {16'h0, v}));  // logic ops zero extend
      issue('0);
    end
    issue(rtype(ADDU, 5'd0, 5'd5, 5'd6, 5'd0));  // r0 must stay zero
    repeat (3) issue('0);
    issue(rtype(ADDU, 5'd9, 5'd0, 5'd0, 5'd0));
    end_test();
  endtask

  task automatic test_forwarding();
    start_test("forwarding");
    for (int d = 1; d < 4; d++) begin
      issue(itype(ADDIU, 5'd20, 5'd0, sext16(16'($urandom))));
      repeat (d - 1) issue('0);
      issue(rtype(ADDU, 5'd21, 5'd5, 5'd20, 5'd0));  // rt side
      issue(itype(ADDIU, 5'd20, 5'd0, sext16(16'($urandom))));
      repeat (d - 1) issue('0);
      issue(rtype(SUBU, 5'd22, 5'd20, 5'd6, 5'd0));  // rs side
    end
    issue(itype(ADDIU, 5'd23, 5'd0, 32'd1));
    issue(itype(ADDIU, 5'd23, 5'd0, 32'd2));  // newer write must win
    issue(rtype(ADDU, 5'd24, 5'd23, 5'd23, 5'd0));
    end_test();
  endtask

  task automatic test_load_store();
    start_test("load_store");
    for (int k = 5; k < 9; k++) begin
      issue(itype(ADDIU, 5'(k), 5'd0, sext16(16'h8080 | 16'($urandom))));  // byte and half msb set
    end
    issue(itype(ADDIU, 5'd30, 5'd0, 32'h100));  // base address
    issue(mem_op(1'b1, BYTE, 1'b0, 5'd5, 5'd30, 32'h1));
    issue(mem_op(1'b1, BYTE, 1'b0, 5'd6, 5'd30, 32'h2));
    issue(mem_op(1'b1, HALF, 1'b0, 5'd7, 5'd30, 32'h6));
    issue(mem_op(1'b1, HALF, 1'b0, 5'd8, 5'd30, 32'h8));
    issue(mem_op(1'b1, WORD, 1'b0, 5'd1, 5'd30, 32'hc));
    issue(mem_op(1'b0, BYTE, 1'b0, 5'd12, 5'd30, 32'h1));
    issue(mem_op(1'b0, BYTE, 1'b1, 5'd13, 5'd30, 32'h2));
    issue(mem_op(1'b0, HALF, 1'b0, 5'd14, 5'd30, 32'h6));
    issue(mem_op(1'b0, HALF, 1'b1, 5'd15, 5'd30, 32'h8));
    issue(mem_op(1'b0, WORD, 1'b0, 5'd16, 5'd30, 32'hc));
    issue('0);  // no load use in the next slot
    issue(rtype(ADDU, 5'd17, 5'd16, 5'd12, 5'd0));
    end_test();
  endtask

  task automatic test_store_fwd_jump();
    start_test("store_fwd_jump");
    issue(itype(ADDIU, 5'd25, 5'd0, sext16(16'($urandom))));
    issue(mem_op(1'b1, WORD, 1'b0, 5'd25, 5'd30, 32'h40));  // data from the bypass
    issue('0);
    issue(mem_op(1'b0, WORD, 1'b0, 5'd26, 5'd30, 32'h40));
    issue(itype(ADDIU, 5'd27, 5'd0, 32'h123));
    issue(jump(1'b0, 5'd27, 32'h0000_1008));  // bank still holds the old value
    issue(itype(ADDIU, 5'd27, 5'd0, 32'h456));
    issue(jump(1'b1, 5'd27, 32'h0000_2008));
    end_test();
  endtask

  always @(negedge i_clk) begin
    if (i_reset || due_q.size() == 0) begin
      check(test_name, 38'd0, {5'd0, o_wb.write, o_wb.data});  // idle pipe stays quiet
    end else if (due_q[0] == cyc) begin
      exp_head = exp_q.pop_front();
      void'(due_q.pop_front());
      if (exp_head.write) check(test_name, exp_head, o_wb);
      else check(test_name, 38'd0, {o_wb.write, 37'd0});
    end
    cyc++;
    if (cyc > MAX_CYCLES) begin
      $display("timeout: run exceeded %0d cycles in test %s", MAX_CYCLES, test_name);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'h01fb_120f));
    i_reset = 1'b1;
    id_ex = '0;
    cyc = 0;
    checks = 0;
    errors = 0;
    test_name = "reset";
    for (int i = 0; i < 32; i++) begin
      regs_m[i] = 32'h0;
      bank_m[i] = 32'h0;
    end
    repeat (10) @(posedge i_clk);
    i_reset <= 1'b0;
    test_reset();
    test_alu();
    test_forwarding();
    test_load_store();
    test_store_fwd_jump();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
